// ==== rename_pkg.sv ====
// rename core shared definitions
// widths, instruction views and the packets passed between the stages
`default_nettype none

package rename_pkg;

    localparam int xlen       = 32;     // data width
    localparam int arch_regs  = 32;     // architectural registers
    localparam int phys_regs  = 64;     // physical registers
    localparam int ar_w       = 5;      // arch index width
    localparam int pr_w       = 6;      // phys index width
    localparam int free_depth = 32;     // free list slots
    localparam int fl_w       = 5;      // free list pointer width

    // rv32 encodings, subset only
    localparam logic [6:0] op_reg     = 7'b0110011;
    localparam logic [6:0] op_imm     = 7'b0010011;
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_sub     = 7'b0100000;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_t;

    typedef struct packed {
        logic [6:0]      funct7;
        logic [ar_w-1:0] rs2;
        logic [ar_w-1:0] rs1;
        logic [2:0]      funct3;
        logic [ar_w-1:0] rd;
        logic [6:0]      opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]     imm;           // sign extended in decode
        logic [ar_w-1:0] rs1;
        logic [2:0]      funct3;
        logic [ar_w-1:0] rd;
        logic [6:0]      opcode;
    } inst_i_t;

    // same word, two field layouts
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef struct packed {
        logic            valid;
        logic            illegal;
        alu_op_t         op;
        logic            use_imm;
        logic [xlen-1:0] imm;
        logic [pr_w-1:0] src1_pr;
        logic [pr_w-1:0] src2_pr;
        logic            dest_en;       // allocated a new phys reg
        logic [pr_w-1:0] dest_pr;
        logic [ar_w-1:0] dest_ar;
        logic [pr_w-1:0] old_pr;        // previous mapping of dest_ar
    } dispatch_t;

    typedef struct packed {
        logic            valid;
        logic            illegal;
        logic            dest_en;
        logic [ar_w-1:0] dest_ar;
        logic [pr_w-1:0] old_pr;
        logic [xlen-1:0] value;
    } result_t;

    typedef struct packed {
        logic            valid;
        logic [pr_w-1:0] pr;
    } free_t;

endpackage

`default_nettype wire

// ==== rename_decode.sv ====
// rename decode stage
// decodes one instruction per cycle, looks up source tags in the map table,
// pops a free phys reg for the destination and registers the dispatch packet
`timescale 1ns/1ps
`default_nettype none

module rename_decode (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  rename_pkg::inst_u     inst,
    input  rename_pkg::free_t     freed,    // returned reg from retire
    output rename_pkg::dispatch_t disp
);

    logic [rename_pkg::pr_w-1:0] map_table [rename_pkg::arch_regs];
    logic [rename_pkg::pr_w-1:0] fl_mem [rename_pkg::free_depth];
    logic [rename_pkg::fl_w-1:0] fl_head;
    logic [rename_pkg::fl_w-1:0] fl_tail;
    logic [rename_pkg::fl_w:0]   fl_count;  // one extra bit for full

    logic                  illegal;
    logic                  use_imm;
    rename_pkg::alu_op_t   op;
    logic                  alloc;
    logic                  push;
    rename_pkg::dispatch_t disp_next;

    ////////////////////
    // decode
    ////////////////////
    always_comb begin
        illegal = 1'b1;                 // unless matched below
        use_imm = 1'b0;
        op      = rename_pkg::alu_add;
        case (inst.r.opcode)
            rename_pkg::op_reg: begin
                if (inst.r.funct7 == rename_pkg::f7_base) begin
                    illegal = 1'b0;
                    case (inst.r.funct3)
                        rename_pkg::f3_add_sub: op = rename_pkg::alu_add;
                        rename_pkg::f3_xor:     op = rename_pkg::alu_xor;
                        rename_pkg::f3_or:      op = rename_pkg::alu_or;
                        rename_pkg::f3_and:     op = rename_pkg::alu_and;
                        default:                illegal = 1'b1;   // sll, slt etc
                    endcase
                end else if (inst.r.funct7 == rename_pkg::f7_sub &&
                             inst.r.funct3 == rename_pkg::f3_add_sub) begin
                    illegal = 1'b0;
                    op      = rename_pkg::alu_sub;
                end
            end
            rename_pkg::op_imm: begin
                if (inst.i.funct3 == rename_pkg::f3_add_sub) begin   // addi only
                    illegal = 1'b0;
                    use_imm = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // x0 and illegal get no phys reg
    assign alloc = inst_valid && !illegal && (inst.r.rd != '0);
    assign push  = freed.valid;

    always_comb begin
        disp_next.valid   = inst_valid;
        disp_next.illegal = illegal;
        disp_next.op      = op;
        disp_next.use_imm = use_imm;
        disp_next.imm     = {{(rename_pkg::xlen-12){inst.i.imm[11]}}, inst.i.imm};
        disp_next.src1_pr = map_table[inst.r.rs1];
        disp_next.src2_pr = map_table[inst.r.rs2];      // unused for addi
        disp_next.dest_en = alloc;
        disp_next.dest_pr = fl_mem[fl_head];
        disp_next.dest_ar = inst.r.rd;
        disp_next.old_pr  = map_table[inst.r.rd];
    end

    ////////////////////
    // map table, free list
    ////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                map_table[i] <= rename_pkg::pr_w'(i);   // identity map
            end
            for (int i = 0; i < rename_pkg::free_depth; i++) begin
                fl_mem[i] <= rename_pkg::pr_w'(rename_pkg::arch_regs + i);  // upper half free
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (rename_pkg::fl_w+1)'(rename_pkg::free_depth);
        end else begin
            if (alloc) begin
                map_table[inst.r.rd] <= fl_mem[fl_head];
                fl_head              <= fl_head + 1'b1;
            end
            if (push) begin
                fl_mem[fl_tail] <= freed.pr;
                fl_tail         <= fl_tail + 1'b1;
            end
            case ({push, alloc})
                2'b10:   fl_count <= fl_count + 1'b1;
                2'b01:   fl_count <= fl_count - 1'b1;
                default: ;      // both or neither, no change
            endcase
        end
    end

    always_ff @(posedge clock) begin
        disp <= disp_next;
        if (reset) disp.valid <= 1'b0;
    end

    // retire returns one reg per allocation, so the list stays in range
    a_free_list_bounds: assert property (@(posedge clock) disable iff (reset)
        !(alloc && fl_count == '0) &&
        !(push && fl_count == (rename_pkg::fl_w+1)'(rename_pkg::free_depth)));

endmodule

`default_nettype wire

// ==== alu_execute.sv ====
// integer execute stage
// reads operands from the physical register file, computes the alu result,
// writes it back and registers the result packet for retire
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  logic                  clock,
    input  logic                  reset,
    input  rename_pkg::dispatch_t disp,
    output rename_pkg::result_t   res
);

    logic [rename_pkg::xlen-1:0] prf [rename_pkg::phys_regs];

    logic [rename_pkg::xlen-1:0] opa;
    logic [rename_pkg::xlen-1:0] opb;
    logic [rename_pkg::xlen-1:0] alu_out;
    logic                        wr_en;

    ////////////////////
    // operands, alu
    ////////////////////
    // writes land at the edge before a dependent reads, no bypass needed
    assign opa = prf[disp.src1_pr];
    assign opb = disp.use_imm ? disp.imm : prf[disp.src2_pr];

    always_comb begin
        case (disp.op)
            rename_pkg::alu_add: alu_out = opa + opb;
            rename_pkg::alu_sub: alu_out = opa - opb;
            rename_pkg::alu_and: alu_out = opa & opb;
            rename_pkg::alu_or:  alu_out = opa | opb;
            rename_pkg::alu_xor: alu_out = opa ^ opb;
            default:             alu_out = '0;
        endcase
    end

    assign wr_en = disp.valid && disp.dest_en;

    ////////////////////
    // register file
    ////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::phys_regs; i++) begin
                prf[i] <= '0;
            end
        end else if (wr_en) begin
            prf[disp.dest_pr] <= alu_out;
        end
    end

    // result packet to retire
    always_ff @(posedge clock) begin
        res.valid   <= disp.valid;
        res.illegal <= disp.illegal;
        res.dest_en <= disp.dest_en;
        res.dest_ar <= disp.dest_ar;
        res.old_pr  <= disp.old_pr;
        res.value   <= disp.dest_en ? alu_out : '0;    // x0 and illegal report zero
        if (reset) res.valid <= 1'b0;
    end

    // p0 backs x0 and never comes off the free list
    a_no_write_p0: assert property (@(posedge clock) disable iff (reset)
        wr_en |-> disp.dest_pr != '0);

endmodule

`default_nettype wire

// ==== retire_result.sv ====
// in-order retire stage
// puts each result on the commit port, counts retired instructions and
// hands the overwritten phys reg back to the free list
`timescale 1ns/1ps
`default_nettype none

module retire_result (
    input  logic                        clock,
    input  logic                        reset,
    input  rename_pkg::result_t         res,
    output rename_pkg::free_t           freed,
    output logic                        commit_valid,
    output logic                        commit_illegal,
    output logic [rename_pkg::ar_w-1:0] commit_rd,
    output logic [rename_pkg::xlen-1:0] commit_value,
    output logic [15:0]                 retired_count
);

    // old mapping is dead once its overwriter retires
    assign freed.valid = res.valid && res.dest_en;
    assign freed.pr    = res.old_pr;

    ////////////////////
    // commit port
    ////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid  <= 1'b0;
            retired_count <= '0;
        end else begin
            commit_valid <= res.valid;
            if (res.valid) retired_count <= retired_count + 1'b1;   // wraps
        end
    end

    always_ff @(posedge clock) begin
        if (res.valid) begin           // payload holds between commits
            commit_illegal <= res.illegal;
            commit_rd      <= res.dest_ar;
            commit_value   <= res.value;
        end
    end

    // only legal writes to a nonzero rd allocate, so only those free
    a_freed_from_retire: assert property (@(posedge clock) disable iff (reset)
        freed.valid |-> !res.illegal && res.dest_ar != '0);

endmodule

`default_nettype wire

// ==== rename_core.sv ====
// rename core top level
// decode/rename, execute and retire in a fixed 3-cycle pipeline
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        inst_valid,
    input  logic [31:0]                 inst,
    output logic                        commit_valid,
    output logic                        commit_illegal,
    output logic [rename_pkg::ar_w-1:0] commit_rd,
    output logic [rename_pkg::xlen-1:0] commit_value,
    output logic [15:0]                 retired_count
);

    rename_pkg::dispatch_t disp;    // decode -> execute
    rename_pkg::result_t   res;     // execute -> retire
    rename_pkg::free_t     freed;   // retire -> free list

    rename_decode i_decode (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),         // raw word into the union view
        .freed      (freed),
        .disp       (disp)
    );

    alu_execute i_execute (
        .clock (clock),
        .reset (reset),
        .disp  (disp),
        .res   (res)
    );

    retire_result i_retire (
        .clock          (clock),
        .reset          (reset),
        .res            (res),
        .freed          (freed),
        .commit_valid   (commit_valid),
        .commit_illegal (commit_illegal),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .retired_count  (retired_count)
    );

endmodule

`default_nettype wire

// ==== tb_rename_core.sv ====
// rename core testbench
// replays instruction words from the data file, one per cycle with idle gaps,
// and checks every commit against the expected values in the file
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core;

    typedef struct packed {
        logic                        illegal;
        logic [rename_pkg::ar_w-1:0] rd;
        logic [rename_pkg::xlen-1:0] value;
        logic [31:0]                 due_edge;  // edge index where the commit shows
    } expect_t;

    logic                        clock;
    logic                        reset;
    logic                        inst_valid;
    logic [31:0]                 inst;
    logic                        commit_valid;
    logic                        commit_illegal;
    logic [rename_pkg::ar_w-1:0] commit_rd;
    logic [rename_pkg::xlen-1:0] commit_value;
    logic [15:0]                 retired_count;

    expect_t     exp_q [$];     // in input order
    int unsigned edge_count;
    int unsigned check_count;
    int unsigned error_count;
    int unsigned sent_count;
    logic [31:0] lcg_state;

    rename_core i_dut (
        .clock          (clock),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .commit_valid   (commit_valid),
        .commit_illegal (commit_illegal),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .retired_count  (retired_count)
    );

    always #4 clock = ~clock;   // 8 ns period

    always @(posedge clock) edge_count <= edge_count + 1;

    ////////////////////
    // helpers
    ////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h",
                     $time, name, got, expected);
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic issue_inst(input logic [31:0] word, input logic illegal,
                              input logic [4:0] rd, input logic [31:0] value);
        expect_t e;
        e.illegal  = illegal;
        e.rd       = rd;
        e.value    = value;
        e.due_edge = edge_count + 3;    // sampled at next edge, commit 2 edges later
        inst_valid = 1'b1;
        inst       = word;
        exp_q.push_back(e);
        sent_count++;
        @(negedge clock);
    endtask

    task automatic idle_cycles(input int n);
        inst_valid = 1'b0;
        repeat (n) @(negedge clock);
    endtask

    ////////////////////
    // commit monitor
    ////////////////////
    always @(negedge clock) begin : commit_monitor
        expect_t head;
        if (!reset && commit_valid) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("unexpected commit at %0t ns with nothing outstanding", $time);
            end else begin
                head = exp_q.pop_front();
                check_value("commit_illegal", 32'(commit_illegal), 32'(head.illegal));
                check_value("commit_rd", 32'(commit_rd), 32'(head.rd));
                check_value("commit_value", commit_value, head.value);
                check_value("commit edge", edge_count, head.due_edge);  // 3 edge latency
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////
    initial begin : main
        int          fd;
        int          n;
        int          gap;
        int          reps;
        int          ill;
        int          rd;
        int          wait_cycles;
        logic [31:0] word;
        logic [31:0] value;
        logic [31:0] step;
        string       line;
        clock       = 1'b0;
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        edge_count  = 0;
        check_count = 0;
        error_count = 0;
        sent_count  = 0;
        lcg_state   = 32'h4f3a_14aa;

        repeat (10) @(negedge clock);   // reset for 10 cycles
        reset = 1'b0;
        idle_cycles(2);

        fd = $fopen("rename_core_testdata.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open rename_core_testdata.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() == 0 || line[0] == "#") continue;     // column notes
                n = $sscanf(line, "%d %d %h %d %d %h %h",
                            gap, reps, word, ill, rd, value, step);
                if (n != 7) begin
                    if (n > 0) begin
                        error_count++;
                        $display("data file line could not be parsed: %s", line);
                    end
                    continue;
                end
                // zero gaps stay back to back for dependent chains
                if (gap > 0) begin
                    lcg_state = lcg_next(lcg_state);
                    gap = gap + int'((lcg_state >> 16) % 3);
                end
                idle_cycles(gap);
                for (int k = 0; k < reps; k++) begin
                    issue_inst(word, ill[0], rd[4:0], value);
                    value = value + step;           // repeated word accumulates
                end
            end
            $fclose(fd);
        end

        // drain the pipeline
        inst_valid  = 1'b0;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 200) begin
            @(negedge clock);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            error_count++;
            $display("timeout: %0d commits still missing after 200 cycles", exp_q.size());
        end
        idle_cycles(4);     // any stray commit shows up here
        check_value("retired_count", 32'(retired_count), sent_count);

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_core_testdata.txt ====
# gap reps word illegal rd value step  (gap, reps, illegal, rd decimal; word, value, step hex)
# reps above 1 issues the word back to back, value growing by step each time
0 1 12300093 0 1  00000123 0
0 1 45600113 0 2  00000456 0
0 1 fff08193 0 3  00000122 0
0 1 7ff10213 0 4  00000c55 0
0 1 80000293 0 5  fffff800 0
2 1 00208333 0 6  00000579 0
0 1 403303b3 0 7  00000457 0
0 1 0043f433 0 8  00000455 0
0 1 005460b3 0 1  fffffc55 0
0 1 0060c133 0 2  fffff92c 0
0 1 403181b3 0 3  00000000 0
0 1 00110233 0 4  fffff581 0
1 1 00508013 0 0  00000000 0
0 1 00208033 0 0  00000000 0
0 1 000002b3 0 5  00000000 0
0 1 00404333 0 6  fffff581 0
3 1 ffffffff 1 31 00000000 0
0 1 002093b3 1 7  00000000 0
0 1 0000a403 1 8  00000000 0
0 1 0010a093 1 1  00000000 0
0 1 022081b3 1 3  00000000 0
0 1 008384b3 0 9  000008ac 0
0 1 0030e533 0 10 fffffc55 0
2 1 3e800593 0 11 000003e8 0
0 40 00358593 0 11 000003eb 3
1 35 ffb60613 0 12 fffffffb fffffffb
0 1 00c586b3 0 13 000003b1 0
0 1 40968733 0 14 fffffb05 0
0 1 00a777b3 0 15 fffff805 0
0 1 00f7c0b3 0 1  00000000 0
4 1 7ff08813 0 16 000007ff 0

// ==== flist.f ====
rename_pkg.sv
rename_decode.sv
alu_execute.sv
retire_result.sv
rename_core.sv
tb_rename_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_rename_core
FLIST      ?= flist.f
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
